// File: test/lsu_cases.txt
// op size ext opa opb incr wdata regoff mem1 mem2 be1 be2 exp_wdata exp_rdata
// op 0 load 1 store, size 0 word 1 half 2 byte, ext 0 zero 1 sign 2 ones, ff ends
1 0 0 00001000 00000000 0 11223344 0 00000000 00000000 f 0 11223344 00000000
1 2 0 00001000 00000001 1 000000ab 0 00000000 00000000 2 0 0000ab00 00000000
1 2 0 00001000 00000003 1 000000ef 0 00000000 00000000 8 0 ef000000 00000000
1 1 0 00001000 00000000 0 0000beef 0 00000000 00000000 3 0 0000beef 00000000
1 1 0 00001000 00000002 1 0000cafe 0 00000000 00000000 c 0 cafe0000 00000000
1 1 0 00001001 00000000 0 00001234 0 00000000 00000000 6 0 00123400 00000000
1 2 0 00001002 00000000 0 0000ab00 1 00000000 00000000 4 0 00ab0000 00000000
1 1 0 00001003 00000000 0 0000a55a 0 00000000 00000000 8 1 5a0000a5 00000000
1 0 0 00001001 00000000 0 11223344 0 00000000 00000000 e 1 22334411 00000000
1 0 0 00001000 00000002 1 aabbccdd 0 00000000 00000000 c 3 ccddaabb 00000000
1 0 0 00001003 00000000 0 01020304 0 00000000 00000000 8 7 04010203 00000000
0 0 0 00002000 00000000 0 00000000 0 a1b2c3d4 00000000 f 0 00000000 a1b2c3d4
0 2 0 00002000 00000000 0 00000000 0 a1b2c3d4 00000000 1 0 00000000 000000d4
0 2 1 00002001 00000000 0 00000000 0 a1b2c3d4 00000000 2 0 00000000 ffffffc3
0 2 2 00002002 00000000 0 00000000 0 a1b2c3d4 00000000 4 0 00000000 ffffffb2
0 2 1 00002000 00000003 1 00000000 0 a1b2c3d4 00000000 8 0 00000000 ffffffa1
0 2 2 00002000 00000000 0 00000000 0 15263748 00000000 1 0 00000000 ffffff48
0 1 1 00002000 00000000 0 00000000 0 a1b2c3d4 00000000 3 0 00000000 ffffc3d4
0 1 0 00002002 00000000 0 00000000 0 a1b2c3d4 00000000 c 0 00000000 0000a1b2
0 1 2 00002001 00000000 0 00000000 0 15263748 00000000 6 0 00000000 ffff2637
0 1 1 00002003 00000000 0 00000000 0 a1b2c3d4 15263748 8 1 00000000 000048a1
0 1 1 00002003 00000000 0 00000000 0 15263748 a1b2c3d4 8 1 00000000 ffffd415
0 0 0 00002001 00000000 0 00000000 0 a1b2c3d4 15263748 e 1 00000000 48a1b2c3
0 0 0 00002000 00000002 1 00000000 0 a1b2c3d4 15263748 c 3 00000000 3748a1b2
0 0 0 00002003 00000000 0 00000000 0 a1b2c3d4 15263748 8 7 00000000 263748a1
ff

// File: verilog.f
+incdir+include
verilog/lsu_pkg.sv
verilog/lsu_store_prep.sv
verilog/lsu_bus_ctrl.sv
verilog/lsu_load_align.sv
verilog/lsu_top.sv
test/lsu_tb.sv

// File: Makefile
SIM = obj_dir/lsu_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f verilog.f --top-module lsu_tb -o lsu_sim --Mdir obj_dir

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "TESTS PASSED"; then \
	  exit 0; \
	else \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir

// File: test/lsu_tb.sv
`include "lsu_consts.svh"

module lsu_tb import lsu_pkg::*; ();

  localparam int NFIELDS   = 14;  // Hex columns per case line
  localparam int MAX_CASES = 64;

  logic                   clk;
  logic                   rst_n;
  logic                   data_req_ex_i;
  lsu_req_t               req_ex_i;
  logic [`LSU_DATA_W-1:0] operand_a_ex_i;
  logic [`LSU_DATA_W-1:0] operand_b_ex_i;
  logic                   addr_useincr_ex_i;
  logic                   data_misaligned_ex_i;
  logic                   data_misaligned_o;
  logic [`LSU_DATA_W-1:0] data_rdata_ex_o;
  logic                   data_req_o;
  logic                   data_gnt_i;
  logic                   data_rvalid_i;
  logic [`LSU_DATA_W-1:0] data_addr_o;
  logic                   data_we_o;
  logic [`LSU_BE_W-1:0]   data_be_o;
  logic [`LSU_DATA_W-1:0] data_wdata_o;
  logic [`LSU_DATA_W-1:0] data_rdata_i;
  logic                   lsu_ready_ex_o;
  logic                   lsu_ready_wb_o;
  logic                   busy_o;

  logic [31:0] cases [0:MAX_CASES*NFIELDS-1];
  int          n_cases = 0;
  logic [31:0] mem_word1;   // Response to the first phase
  logic [31:0] mem_word2;   // Response to the second phase
  logic [31:0] lcg_state = 32'd50;

  lsu_top lsu_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic stop_run();
    $display("TESTS FAILED");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  ////////////////////////////////////////////////////
  // Data-bus memory model and bus monitor
  ////////////////////////////////////////////////////

  initial begin
    logic [31:0] resp_data_q [$];
    int          resp_due_q [$];
    int          cycle;
    int          outstanding;  // Grants minus responses
    logic        prev_stall;   // Request was held without grant
    logic [68:0] prev_phase;
    cycle       = 0;
    outstanding = 0;
    prev_stall  = 1'b0;
    prev_phase  = '0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    forever begin
      @(negedge clk);
      cycle++;
      lcg_state  = lcg_next(lcg_state);
      data_gnt_i = lcg_state[16];  // Grant on about half the cycles
      data_rvalid_i = (resp_due_q.size() != 0) && (resp_due_q[0] <= cycle);
      data_rdata_i  = data_rvalid_i ? resp_data_q[0] : '0;
      #5;
      if (outstanding > 2) begin
        $display("More than two transactions in flight");
        stop_run();
      end
      // Status levels follow the count of transactions in flight
      check_value("busy_o", 32'(busy_o), 32'(outstanding != 0 || data_req_ex_i));
      check_value("lsu_ready_wb_o", 32'(lsu_ready_wb_o),
                  32'(outstanding == 0 || data_rvalid_i));
      if (data_req_o && !data_gnt_i)
        check_value("lsu_ready_ex_o", 32'(lsu_ready_ex_o), 32'd0);  // Not before the grant
      // Address phase must not move under back-pressure
      if (prev_stall && data_req_o)
        check_value("data_addr_o held", data_addr_o, prev_phase[68:37]);
      if (prev_stall && data_req_o)
        check_value("data_we_o held", 32'(data_we_o), 32'(prev_phase[36]));
      if (prev_stall && data_req_o)
        check_value("data_be_o held", 32'(data_be_o), 32'(prev_phase[35:32]));
      if (prev_stall && data_req_o)
        check_value("data_wdata_o held", data_wdata_o, prev_phase[31:0]);
      prev_stall = data_req_o && !data_gnt_i;
      prev_phase = {data_addr_o, data_we_o, data_be_o, data_wdata_o};
      if (data_rvalid_i) begin
        void'(resp_data_q.pop_front());
        void'(resp_due_q.pop_front());
        outstanding--;
      end
      if (data_req_o && data_gnt_i) begin
        resp_data_q.push_back(data_misaligned_ex_i ? mem_word2 : mem_word1);
        resp_due_q.push_back(cycle + 1 + int'(lcg_state[18:17]));  // At least next cycle
        outstanding++;
      end
    end
  end

  // Wait for EX acceptance between clock edges
  task automatic wait_accept();
    #5;
    while (!(lsu_ready_ex_o && data_req_ex_i)) begin
      @(negedge clk);
      #5;
    end
  endtask

  ////////////////////////////////////////////////////
  // One access from the case file
  ////////////////////////////////////////////////////

  task automatic run_case(input int c);
    logic [31:0] f [NFIELDS];
    logic [31:0] addr_exp;
    logic        mis_exp;
    for (int k = 0; k < NFIELDS; k++) f[k] = cases[c*NFIELDS + k];
    addr_exp = f[5][0] ? f[3] + f[4] : f[3];
    mis_exp  = (f[11] != 32'd0);  // Phase-2 enables given only for split accesses
    @(negedge clk);
    req_ex_i.we         = f[0][0];
    req_ex_i.data_type  = data_type_e'(f[1][1:0]);
    req_ex_i.sign_ext   = sign_ext_e'(f[2][1:0]);
    req_ex_i.reg_offset = f[7][1:0];
    req_ex_i.wdata      = f[6];
    operand_a_ex_i      = f[3];
    operand_b_ex_i      = f[4];
    addr_useincr_ex_i   = f[5][0];
    mem_word1           = f[8];
    mem_word2           = f[9];
    data_misaligned_ex_i = 1'b0;
    data_req_ex_i        = 1'b1;
    wait_accept();
    check_value("data_misaligned_o", 32'(data_misaligned_o), 32'(mis_exp));
    check_value("data_addr_o", data_addr_o, addr_exp);
    check_value("data_we_o", 32'(data_we_o), 32'(f[0][0]));
    check_value("data_be_o", 32'(data_be_o), f[10]);
    if (f[0][0]) check_value("data_wdata_o", data_wdata_o, f[12]);
    if (mis_exp) begin
      // Pipeline replays the access for the next word
      @(negedge clk);
      operand_a_ex_i       = f[3] + 32'd4;
      data_misaligned_ex_i = 1'b1;
      wait_accept();
      check_value("data_misaligned_o", 32'(data_misaligned_o), 32'd0);
      check_value("data_addr_o", data_addr_o, (addr_exp + 32'd4) & ~32'd3);
      check_value("data_be_o", 32'(data_be_o), f[11]);
      if (f[0][0]) check_value("data_wdata_o", data_wdata_o, f[12]);
    end
    @(negedge clk);
    data_req_ex_i        = 1'b0;
    data_misaligned_ex_i = 1'b0;
    // WB ready marks the response of the last phase
    #5;
    while (!lsu_ready_wb_o) begin
      @(negedge clk);
      #5;
    end
    if (!f[0][0]) check_value("data_rdata_ex_o", data_rdata_ex_o, f[13]);
  endtask

  initial begin
    wait (n_cases > 0);
    repeat (n_cases * 100 + 20) @(posedge clk);  // 100 cycles per case
    $display("Watchdog expired before all cases completed");
    stop_run();
  end

  initial begin
    int cnt;
    rst_n                = 1'b0;
    data_req_ex_i        = 1'b0;
    req_ex_i             = '0;
    operand_a_ex_i       = '0;
    operand_b_ex_i       = '0;
    addr_useincr_ex_i    = 1'b0;
    data_misaligned_ex_i = 1'b0;
    mem_word1            = '0;
    mem_word2            = '0;
    $readmemh("test/lsu_cases.txt", cases);
    cnt = 0;
    while (cnt < MAX_CASES && cases[cnt*NFIELDS] != 32'hff) cnt++;  // ff closes the list
    if (cnt == 0) begin
      $display("No cases were read from the case file");
      stop_run();
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #5;
    check_value("busy_o", 32'(busy_o), 32'd0);
    check_value("data_req_o", 32'(data_req_o), 32'd0);
    check_value("lsu_ready_wb_o", 32'(lsu_ready_wb_o), 32'd1);
    check_value("data_rdata_ex_o", data_rdata_ex_o, 32'd0);
    n_cases = cnt;
    for (int c = 0; c < cnt; c++) run_case(c);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: verilog/lsu_top.sv
`include "lsu_consts.svh"

module lsu_top import lsu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  // EX stage
  input  logic                   data_req_ex_i,
  input  lsu_req_t               req_ex_i,
  input  logic [`LSU_DATA_W-1:0] operand_a_ex_i,
  input  logic [`LSU_DATA_W-1:0] operand_b_ex_i,
  input  logic                   addr_useincr_ex_i,
  input  logic                   data_misaligned_ex_i,
  output logic                   data_misaligned_o,
  output logic [`LSU_DATA_W-1:0] data_rdata_ex_o,
  // Data bus
  output logic                   data_req_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  output logic [`LSU_DATA_W-1:0] data_addr_o,
  output logic                   data_we_o,
  output logic [`LSU_BE_W-1:0]   data_be_o,
  output logic [`LSU_DATA_W-1:0] data_wdata_o,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i,
  // Pipeline status
  output logic                   lsu_ready_ex_o,
  output logic                   lsu_ready_wb_o,
  output logic                   busy_o
);

  bus_req_t   bus_req_prep;  // Address phase from EX
  bus_req_t   bus_req_out;   // Address phase on the bus
  load_ctrl_t load_ctrl;
  logic       ctrl_update;
  logic       resp_valid;

  lsu_store_prep lsu_store_prep_i (
    .req_i          (req_ex_i),
    .operand_a_i    (operand_a_ex_i),
    .operand_b_i    (operand_b_ex_i),
    .addr_useincr_i (addr_useincr_ex_i),
    .misaligned_ex_i(data_misaligned_ex_i),
    .bus_req_o      (bus_req_prep),
    .load_ctrl_o    (load_ctrl),
    .misaligned_o   (data_misaligned_o)
  );

  lsu_bus_ctrl lsu_bus_ctrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_req_ex_i (data_req_ex_i),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .bus_req_i     (bus_req_prep),
    .data_req_o    (data_req_o),
    .bus_req_o     (bus_req_out),
    .resp_valid_o  (resp_valid),
    .ctrl_update_o (ctrl_update),
    .lsu_ready_ex_o(lsu_ready_ex_o),
    .lsu_ready_wb_o(lsu_ready_wb_o),
    .busy_o        (busy_o)
  );

  lsu_load_align lsu_load_align_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctrl_update_i  (ctrl_update),
    .load_ctrl_i    (load_ctrl),
    .resp_valid_i   (resp_valid),
    .rdata_i        (data_rdata_i),
    .misaligned_ex_i(data_misaligned_ex_i),
    .misaligned_i   (data_misaligned_o),
    .rdata_o        (data_rdata_ex_o)
  );

  // Split the address phase onto the bus pins
  assign data_addr_o  = bus_req_out.addr;
  assign data_we_o    = bus_req_out.we;
  assign data_be_o    = bus_req_out.be;
  assign data_wdata_o = bus_req_out.wdata;

endmodule

// File: verilog/lsu_load_align.sv
`include "lsu_consts.svh"

module lsu_load_align import lsu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ctrl_update_i,    // Access moves to WB
  input  load_ctrl_t             load_ctrl_i,
  input  logic                   resp_valid_i,     // Response on rdata_i
  input  logic [`LSU_DATA_W-1:0] rdata_i,
  input  logic                   misaligned_ex_i,  // Second phase presented in EX
  input  logic                   misaligned_i,     // First phase still presented in EX
  output logic [`LSU_DATA_W-1:0] rdata_o
);

  load_ctrl_t             ctrl_q;     // Control of the access awaiting response
  logic [`LSU_DATA_W-1:0] rdata_q;    // Held result or first-phase word
  logic [`LSU_DATA_W-1:0] shifted;    // Response moved down to lane 0
  logic [`LSU_DATA_W-1:0] word_asm;
  logic [15:0]            half_sel;
  logic [7:0]             byte_sel;
  logic                   msb;        // Top bit of the selected item
  logic                   fill;       // Extension bit
  logic [`LSU_DATA_W-1:0] rdata_ext;
  logic                   load_resp;  // Response that belongs to a load

  //////////////////////////////////////////////////
  // WB control register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q <= '0;
    end else if (ctrl_update_i) begin
      ctrl_q <= load_ctrl_i;
    end
  end

  //////////////////////////////////////////////////
  // Lane selection and misaligned assembly
  //////////////////////////////////////////////////

  assign shifted  = rdata_i >> {ctrl_q.offset, 3'b000};
  assign byte_sel = shifted[7:0];

  // Half-word at offset 3 straddles two words
  assign half_sel = (ctrl_q.offset == 2'b11) ? {rdata_i[7:0], rdata_q[31:24]} : shifted[15:0];

  // Low part comes from the saved first word
  always_comb begin
    case (ctrl_q.offset)
      2'b00: word_asm = rdata_i;
      2'b01: word_asm = {rdata_i[7:0], rdata_q[31:8]};
      2'b10: word_asm = {rdata_i[15:0], rdata_q[31:16]};
      default: word_asm = {rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  // Extension
  assign msb = (ctrl_q.data_type == DT_HALF) ? half_sel[15] : byte_sel[7];

  always_comb begin
    case (ctrl_q.sign_ext)
      SE_ZERO: fill = 1'b0;
      SE_ONES: fill = 1'b1;
      default: fill = msb;  // Sign, also 2'b11
    endcase
  end

  always_comb begin
    case (ctrl_q.data_type)
      DT_WORD: rdata_ext = word_asm;
      DT_HALF: rdata_ext = {{16{fill}}, half_sel};
      default: rdata_ext = {{24{fill}}, byte_sel};
    endcase
  end

  //////////////////////////////////////////////////
  // Held load data
  //////////////////////////////////////////////////

  assign load_resp = resp_valid_i && !ctrl_q.we;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (load_resp) begin
      // Raw word kept while a split access is under way
      if (misaligned_ex_i || misaligned_i) rdata_q <= rdata_i;
      else rdata_q <= rdata_ext;
    end
  end

  // Live result in the response cycle, held value otherwise
  assign rdata_o = load_resp ? rdata_ext : rdata_q;

endmodule

// File: verilog/lsu_bus_ctrl.sv
`include "lsu_consts.svh"

module lsu_bus_ctrl import lsu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     data_req_ex_i,   // Held by EX until ready
  input  logic     data_gnt_i,
  input  logic     data_rvalid_i,
  input  bus_req_t bus_req_i,
  output logic     data_req_o,
  output bus_req_t bus_req_o,
  output logic     resp_valid_o,    // Response strobe to WB
  output logic     ctrl_update_o,   // Capture control into WB
  output logic     lsu_ready_ex_o,
  output logic     lsu_ready_wb_o,
  output logic     busy_o
);

  logic [`LSU_CNT_W-1:0] cnt_q;       // Transactions in flight
  logic [`LSU_CNT_W-1:0] cnt_d;
  logic                  count_up;    // Request accepted
  logic                  count_down;  // Response received
  logic                  has_room;

  //////////////////////////////////////////////////
  // Request gating
  //////////////////////////////////////////////////

  assign has_room   = cnt_q < `LSU_CNT_W'(`LSU_MAX_OUTSTANDING);
  assign data_req_o = data_req_ex_i && has_room;
  assign bus_req_o  = bus_req_i;  // Address phase held stable by EX

  assign count_up     = data_req_o && data_gnt_i;
  assign count_down   = data_rvalid_i;
  assign resp_valid_o = data_rvalid_i;

  // Outstanding counter, up and down together cancel
  always_comb begin
    cnt_d = cnt_q;
    if (count_up && !count_down) cnt_d = cnt_q + `LSU_CNT_W'(1);
    else if (count_down && !count_up) cnt_d = cnt_q - `LSU_CNT_W'(1);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  //////////////////////////////////////////////////
  // Ready and busy
  //////////////////////////////////////////////////

  assign lsu_ready_wb_o = (cnt_q == '0) ? 1'b1 : data_rvalid_i;

  // EX and WB advance in lock step once WB holds an access
  always_comb begin
    if (!data_req_ex_i) lsu_ready_ex_o = 1'b1;
    else if (cnt_q == `LSU_CNT_W'(0)) lsu_ready_ex_o = count_up;
    else if (cnt_q == `LSU_CNT_W'(1)) lsu_ready_ex_o = data_rvalid_i && count_up;
    else lsu_ready_ex_o = data_rvalid_i;  // Full, request is gated off
  end

  assign ctrl_update_o = lsu_ready_ex_o && data_req_ex_i;
  assign busy_o        = (cnt_q != '0) || data_req_o;

endmodule

// File: verilog/lsu_store_prep.sv
`include "lsu_consts.svh"

module lsu_store_prep import lsu_pkg::*; (
  input  lsu_req_t               req_i,
  input  logic [`LSU_DATA_W-1:0] operand_a_i,
  input  logic [`LSU_DATA_W-1:0] operand_b_i,
  input  logic                   addr_useincr_i,   // A+B when set, A alone otherwise
  input  logic                   misaligned_ex_i,  // Second phase of a split access
  output bus_req_t               bus_req_o,
  output load_ctrl_t             load_ctrl_o,
  output logic                   misaligned_o
);

  logic [`LSU_DATA_W-1:0] addr;          // Effective byte address
  logic [1:0]             offset;        // Byte lane of the first byte
  logic [1:0]             wdata_offset;  // Rotation amount for store data
  logic [`LSU_BE_W-1:0]   be;
  logic [`LSU_DATA_W-1:0] wdata;

  //////////////////////////////////////////////////
  // Address generation
  //////////////////////////////////////////////////

  assign addr   = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign offset = addr[1:0];

  //////////////////////////////////////////////////
  // Byte enables
  //////////////////////////////////////////////////

  always_comb begin
    case (req_i.data_type)
      DT_WORD: begin
        // Phase 2 covers the bytes that spilled past the word boundary
        if (misaligned_ex_i) be = {`LSU_BE_W{1'b1}} >> (3'd4 - {1'b0, offset});
        else be = {`LSU_BE_W{1'b1}} << offset;
      end
      DT_HALF: begin
        if (misaligned_ex_i) be = `LSU_BE_W'(1);  // Upper byte only, lane 0
        else be = `LSU_BE_W'(3) << offset;        // Truncates at offset 3
      end
      default: be = `LSU_BE_W'(1) << offset;    // Byte, also 2'b11
    endcase
  end

  //////////////////////////////////////////////////
  // Store data rotation
  //////////////////////////////////////////////////

  // Register offset already places data partly, rotate only the rest
  assign wdata_offset = offset - req_i.reg_offset;

  always_comb begin
    case (wdata_offset)
      2'b00: wdata = req_i.wdata;
      2'b01: wdata = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'b10: wdata = {req_i.wdata[15:0], req_i.wdata[31:16]};
      default: wdata = {req_i.wdata[7:0], req_i.wdata[31:8]};
    endcase
  end

  // Misaligned check, first phase only
  always_comb begin
    misaligned_o = 1'b0;
    if (!misaligned_ex_i) begin
      case (req_i.data_type)
        DT_WORD: misaligned_o = (offset != 2'b00);
        DT_HALF: misaligned_o = (offset == 2'b11);
        default: misaligned_o = 1'b0;  // Bytes never cross a word
      endcase
    end
  end

  // Address phase, second phase starts at the next word boundary
  assign bus_req_o.addr  = misaligned_ex_i ? {addr[`LSU_DATA_W-1:2], 2'b00} : addr;
  assign bus_req_o.we    = req_i.we;
  assign bus_req_o.be    = be;
  assign bus_req_o.wdata = wdata;

  // Control carried into WB
  assign load_ctrl_o.we        = req_i.we;
  assign load_ctrl_o.data_type = req_i.data_type;
  assign load_ctrl_o.sign_ext  = req_i.sign_ext;
  assign load_ctrl_o.offset    = offset;  // Unaligned offset also in phase 2

endmodule

// File: verilog/lsu_pkg.sv
`include "lsu_consts.svh"

package lsu_pkg;

  // Access size, 2'b11 decodes as byte
  typedef enum logic [1:0] {
    DT_WORD = 2'b00,
    DT_HALF = 2'b01,
    DT_BYTE = 2'b10
  } data_type_e;

  // Fill used above a loaded byte or half-word
  typedef enum logic [1:0] {
    SE_ZERO = 2'b00,
    SE_SIGN = 2'b01,
    SE_ONES = 2'b10
  } sign_ext_e;

  typedef struct packed {
    logic                   we;          // Store when set
    data_type_e             data_type;
    sign_ext_e              sign_ext;
    logic [1:0]             reg_offset;  // Byte position of data inside the register
    logic [`LSU_DATA_W-1:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic [`LSU_DATA_W-1:0] addr;
    logic                   we;
    logic [`LSU_BE_W-1:0]   be;
    logic [`LSU_DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic       we;
    data_type_e data_type;
    sign_ext_e  sign_ext;
    logic [1:0] offset;  // Unaligned byte offset, kept for both phases
  } load_ctrl_t;

endpackage

// File: include/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

//////////////////////////////////////////////////
// Data bus geometry
//////////////////////////////////////////////////

// Address and data width of the data bus
`define LSU_DATA_W 32
// One enable per byte lane
`define LSU_BE_W 4

// Bus transactions allowed in flight at once
`define LSU_MAX_OUTSTANDING 2
// Counter must hold 0 up to LSU_MAX_OUTSTANDING
`define LSU_CNT_W 2

`endif
